//--- tb.f
+incdir+include
source/booth_arith_pkg.sv
source/booth_pipe_pkg.sv
source/ripple_carry_adder.sv
source/booth_operand_stage.sv
source/booth_stage.sv
source/booth_multiplier.sv
dv/booth_multiplier_tb.sv

//--- Makefile
# Verilator build and run for the Booth multiplier testbench

VERILATOR ?= verilator
TOP ?= booth_multiplier_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard source/*.sv) $(wildcard include/*.svh) $(wildcard dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides pass or fail
run: build
	./$(SIM_BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/booth_vectors.svh
`ifndef BOOTH_VECTORS_SVH
`define BOOTH_VECTORS_SVH

//////////////////////////////////////////////////
// Directed operand pairs
//////////////////////////////////////////////////

localparam int BOOTH_VECTOR_COUNT = 16;

// Each entry is {a, b, expected product}, 8 + 8 + 16 bits
localparam logic [31:0] BOOTH_VECTORS [BOOTH_VECTOR_COUNT] = '{
	// Zero and one
	{8'h00, 8'h00, 16'h0000},
	{8'h01, 8'h01, 16'h0001},
	{8'h00, 8'h7f, 16'h0000},
	{8'h01, 8'hff, 16'hffff},
	// Positive times negative
	{8'h05, 8'hfd, 16'hfff1},
	{8'hf9, 8'h09, 16'hffc1},
	// Negative times negative
	{8'hff, 8'hff, 16'h0001},
	{8'hfb, 8'hfa, 16'h001e},
	// Alternating bits
	{8'h55, 8'haa, 16'he372},
	{8'haa, 8'haa, 16'h1ce4},
	{8'h55, 8'h55, 16'h1c39},
	// Extremes of the range
	{8'h80, 8'h80, 16'h4000},
	{8'h80, 8'h7f, 16'hc080},
	{8'h7f, 8'h7f, 16'h3f01},
	{8'h80, 8'h01, 16'hff80},
	{8'h7f, 8'h80, 16'hc080}
};

`endif

//--- dv/booth_multiplier_tb.sv
`timescale 1ns/1ns

module booth_multiplier_tb
	import booth_arith_pkg::*;
();

	`include "booth_vectors.svh"

	//////////////////////////////////////////////////
	// Run lengths
	//////////////////////////////////////////////////

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 2;
	localparam int IDLE_CYCLES = 10;
	localparam int DUT_STEPS_PER_STAGE = 2;
	localparam int unsigned LATENCY = 1 + OPERAND_WIDTH / DUT_STEPS_PER_STAGE;
	localparam int TABLE_GAP = 3;
	localparam int RANDOM_COUNT = 200;
	localparam int MAX_GAP = 3;

	// Every phase at its longest, then the drain
	localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES
		+ BOOTH_VECTOR_COUNT * (2 + TABLE_GAP)
		+ RANDOM_COUNT * (1 + MAX_GAP)
		+ LATENCY + 50;

	typedef enum logic [1:0] {
		kind_table,
		kind_spaced,
		kind_random
	} test_kind_t;

	// One start waiting for its result
	typedef struct packed {
		test_kind_t kind;
		logic [15:0] index;
		product_t expected;
		logic [31:0] start_cycle;
	} pending_t;

	logic clk;
	logic reset;
	logic start;
	operand_t a;
	operand_t b;
	logic done;
	product_t product;

	int unsigned cycle_count = 0;
	pending_t pending_q [$];

	booth_multiplier booth_multiplier_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.a(a),
		.b(b),
		.done(done),
		.product(product)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Reference product, sign-extended operands in the product width
	function automatic product_t signed_product(input operand_t x, input operand_t y);
		return product_t'(x) * product_t'(y);
	endfunction

	function automatic string test_name(input test_kind_t kind, input int index);
		case (kind)
			kind_table: return $sformatf("table[%0d]", index);
			kind_spaced: return $sformatf("spaced table[%0d]", index);
			default: return $sformatf("random[%0d]", index);
		endcase
	endfunction

	task automatic wait_cycles(input int count);
		repeat (count) @(negedge clk);
	endtask

	// Called at a falling edge, leaves start low at the next one
	task automatic send_pair(input test_kind_t kind, input int index,
			input operand_t x, input operand_t y);
		pending_t item;
		item.kind = kind;
		item.index = 16'(index);
		item.expected = signed_product(x, y);
		item.start_cycle = cycle_count;
		start = 1'b1;
		a = x;
		b = y;
		pending_q.push_back(item);
		@(negedge clk);
		start = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Cycle counter and timeout
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$fatal(1, "Simulation stopped on timeout");
		end
	end

	//////////////////////////////////////////////////
	// Result monitor
	//////////////////////////////////////////////////

	always @(negedge clk) begin : monitor_results
		pending_t item;
		string name;
		if (!reset && done === 1'b1) begin
			if (pending_q.size() == 0) begin
				$display("A done pulse came with no start waiting for a result");
				$display("Test FAILED");
				$fatal(1, "Unexpected done");
			end else begin
				item = pending_q.pop_front();
				name = test_name(item.kind, int'(item.index));
				check_value(name, 32'(item.expected), 32'(product));
				check_value({name, " latency"}, LATENCY, cycle_count - item.start_cycle);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin : drive_tests
		int gap;
		operand_t x;
		operand_t y;

		reset = 1'b1;
		start = 1'b0;
		a = '0;
		b = '0;
		void'($urandom(32'hfaff));

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Quiet pipeline after reset
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_value("idle done", 32'h0, 32'(done));
		end

		// Directed table, one start every cycle
		for (int i = 0; i < BOOTH_VECTOR_COUNT; i++) begin
			x = BOOTH_VECTORS[i][31:24];
			y = BOOTH_VECTORS[i][23:16];
			check_value($sformatf("table[%0d] entry", i),
				32'(product_t'(BOOTH_VECTORS[i][15:0])), 32'(signed_product(x, y)));
			send_pair(kind_table, i, x, y);
		end

		// Same table with idle cycles between starts
		for (int i = 0; i < BOOTH_VECTOR_COUNT; i++) begin
			send_pair(kind_spaced, i, BOOTH_VECTORS[i][31:24], BOOTH_VECTORS[i][23:16]);
			wait_cycles(TABLE_GAP);
		end

		for (int i = 0; i < RANDOM_COUNT; i++) begin
			x = operand_t'($urandom);
			y = operand_t'($urandom);
			gap = int'($urandom_range(MAX_GAP, 0));
			send_pair(kind_random, i, x, y);
			wait_cycles(gap);
		end

		// Drain, then watch for stray done pulses
		while (pending_q.size() != 0) @(negedge clk);
		wait_cycles(int'(LATENCY));

		$display("Test OK");
		$finish;
	end

endmodule

//--- source/booth_multiplier.sv
`timescale 1ns/1ns

module booth_multiplier
	import booth_arith_pkg::*, booth_pipe_pkg::*;
#(
	parameter int STEPS_PER_STAGE = 2
) (
	input logic clk,
	input logic reset,
	input logic start,
	input operand_t a,
	input operand_t b,
	output logic done,
	output product_t product
);

	localparam int NUM_STAGES = OPERAND_WIDTH / STEPS_PER_STAGE;

	// Steps must split evenly over the stages
	if (STEPS_PER_STAGE < 1 || OPERAND_WIDTH % STEPS_PER_STAGE != 0) begin : g_param_check
		$error("STEPS_PER_STAGE must divide OPERAND_WIDTH");
	end

	// chain[0] from the operand stage, chain[NUM_STAGES] holds the result
	booth_stage_t chain [NUM_STAGES+1];

	//////////////////////////////////////////////////
	// Operand capture
	//////////////////////////////////////////////////

	booth_operand_stage operand_stage_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.a(a),
		.b(b),
		.stage_out(chain[0])
	);

	//////////////////////////////////////////////////
	// Booth stage chain
	//////////////////////////////////////////////////

	for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
		booth_stage #(
			.STEPS_PER_STAGE(STEPS_PER_STAGE)
		) booth_stage_inst (
			.clk(clk),
			.reset(reset),
			.stage_in(chain[s]),
			.stage_out(chain[s+1])
		);
	end

	// Product is the accumulator over the shifted-out multiplier
	assign product = {chain[NUM_STAGES].acc, chain[NUM_STAGES].mult_q};
	assign done = chain[NUM_STAGES].valid;

endmodule

//--- source/booth_stage.sv
`timescale 1ns/1ns

module booth_stage
	import booth_arith_pkg::*, booth_pipe_pkg::*;
#(
	parameter int STEPS_PER_STAGE = 2
) (
	input logic clk,
	input logic reset,
	input booth_stage_t stage_in,
	output booth_stage_t stage_out
);

	// step[0] is the stage input, step[i+1] the record after step i
	booth_stage_t step [STEPS_PER_STAGE+1];

	assign step[0] = stage_in;

	//////////////////////////////////////////////////
	// Booth steps, add or subtract then shift
	//////////////////////////////////////////////////

	for (genvar i = 0; i < STEPS_PER_STAGE; i++) begin : g_step
		booth_op_t op;
		operand_t addend;
		logic addend_sign;
		operand_t acc_sum;
		logic sum_sign;
		booth_stage_t stepped;

		// Recode on the low multiplier bit and the bit before it
		always_comb begin
			case ({step[i].mult_q[0], step[i].q_prev})
				2'b10: op = op_sub;
				2'b01: op = op_add;
				default: op = op_none;
			endcase
		end

		always_comb begin
			case (op)
				op_sub: begin
					addend = step[i].multiplicand_neg;
					// Negated -2**(W-1) is +2**(W-1) despite its top bit
					addend_sign = step[i].multiplicand_neg[OPERAND_WIDTH-1]
						& ~step[i].multiplicand[OPERAND_WIDTH-1];
				end
				op_add: begin
					addend = step[i].multiplicand;
					addend_sign = step[i].multiplicand[OPERAND_WIDTH-1];
				end
				default: begin
					addend = '0;
					addend_sign = 1'b0;
				end
			endcase
		end

		ripple_carry_adder acc_adder_inst (
			.a(step[i].acc),
			.b(addend),
			.sum(acc_sum)
		);

		// Sign of the sum one bit wider than the accumulator
		assign sum_sign = (step[i].acc[OPERAND_WIDTH-1] == addend_sign) ?
			addend_sign : acc_sum[OPERAND_WIDTH-1];

		// Arithmetic shift of {acc, mult_q} by one, low bit goes to q_prev
		always_comb begin
			stepped = step[i];
			stepped.acc = {sum_sign, acc_sum[OPERAND_WIDTH-1:1]};
			stepped.mult_q = {acc_sum[0], step[i].mult_q[OPERAND_WIDTH-1:1]};
			stepped.q_prev = step[i].mult_q[0];
		end

		assign step[i+1] = stepped;
	end

	//////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		stage_out <= step[STEPS_PER_STAGE];
		if (reset) begin
			stage_out.valid <= 1'b0;
		end
	end

	// No item is lost and the accumulator stays within +-2**(W-2)
	valid_passes: assert property (
		@(posedge clk) disable iff (reset)
		stage_in.valid |=> stage_out.valid
			&& $signed(stage_out.acc) >= -(2 ** (OPERAND_WIDTH - 2))
			&& $signed(stage_out.acc) <= 2 ** (OPERAND_WIDTH - 2)
	);

endmodule

//--- source/booth_operand_stage.sv
`timescale 1ns/1ns

module booth_operand_stage
	import booth_arith_pkg::*, booth_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input operand_t a,
	input operand_t b,
	output booth_stage_t stage_out
);

	operand_t a_inv;
	operand_t a_neg;

	//////////////////////////////////////////////////
	// Negated multiplicand, invert and add one
	//////////////////////////////////////////////////

	assign a_inv = ~a;

	ripple_carry_adder negate_inst (
		.a(a_inv),
		.b(operand_t'(1)),
		.sum(a_neg)
	);

	//////////////////////////////////////////////////
	// Operand register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start) begin
			stage_out.acc <= '0;
			stage_out.mult_q <= b;
			stage_out.q_prev <= 1'b0;
			stage_out.multiplicand <= a;
			stage_out.multiplicand_neg <= a_neg;
		end

		// One valid cycle per start
		if (reset) begin
			stage_out.valid <= 1'b0;
		end else begin
			stage_out.valid <= start;
		end
	end

	// Each start becomes a valid record one cycle later with a true negation
	valid_follows_start: assert property (
		@(posedge clk) disable iff (reset)
		start |=> stage_out.valid
			&& operand_t'(stage_out.multiplicand + stage_out.multiplicand_neg) == '0
	);

endmodule

//--- source/ripple_carry_adder.sv
`timescale 1ns/1ns

module ripple_carry_adder
	import booth_arith_pkg::*;
(
	input operand_t a,
	input operand_t b,
	output operand_t sum
);

	// Carry into each bit position
	logic [OPERAND_WIDTH-1:0] carry;

	assign carry[0] = 1'b0;

	//////////////////////////////////////////////////
	// Full-adder cells
	//////////////////////////////////////////////////

	for (genvar i = 0; i < OPERAND_WIDTH; i++) begin : g_cell
		assign sum[i] = a[i] ^ b[i] ^ carry[i];

		// Carry out of the top cell is dropped
		if (i < OPERAND_WIDTH - 1) begin : g_carry
			assign carry[i+1] = (a[i] & b[i]) | (a[i] & carry[i]) | (b[i] & carry[i]);
		end
	end

endmodule

//--- source/booth_pipe_pkg.sv
package booth_pipe_pkg;

	import booth_arith_pkg::*;

	//////////////////////////////////////////////////
	// Work in flight between pipeline stages
	//////////////////////////////////////////////////

	typedef struct packed {
		logic valid;
		// High half of the partial product
		operand_t acc;
		// Multiplier bits still to recode, low half of the product
		operand_t mult_q;
		// Low bit shifted out by the previous step
		logic q_prev;
		operand_t multiplicand;
		// Two's complement of the multiplicand, used on subtract
		operand_t multiplicand_neg;
	} booth_stage_t;

endpackage

//--- source/booth_arith_pkg.sv
package booth_arith_pkg;

	//////////////////////////////////////////////////
	// Word sizes
	//////////////////////////////////////////////////

	localparam int OPERAND_WIDTH = 8;

	// One operand, also the accumulator word
	typedef logic signed [OPERAND_WIDTH-1:0] operand_t;

	// Accumulator on top, multiplier register below
	typedef logic signed [2*OPERAND_WIDTH-1:0] product_t;

	//////////////////////////////////////////////////
	// Booth recoding
	//////////////////////////////////////////////////

	// From {q[0], q_prev}: 10 subtracts, 01 adds, 00 and 11 pass
	typedef enum logic [1:0] {
		op_none,
		op_add,
		op_sub
	} booth_op_t;

endpackage
